// ==== design/decode_pkg.sv ====
package decode_pkg;

    // widths with a meaning
    typedef logic [31:0] word_t;    // data word or address
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;  // inst[31:26]
    typedef logic [5:0]  funct_t;   // inst[5:0]
    typedef logic [4:0]  shamt_t;
    typedef logic [25:0] jtarget_t; // j / jal field
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  dst_sel_t;
    typedef logic [1:0]  wb_src_t;

    // alu operations
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_SLT = 4'd4;
    localparam alu_op_t ALU_SLL = 4'd5;
    localparam alu_op_t ALU_LUI = 4'd6;
    localparam alu_op_t ALU_NOP = 4'd7;

    // destination register select
    localparam dst_sel_t DST_RT = 2'b00;
    localparam dst_sel_t DST_RD = 2'b01;
    localparam dst_sel_t DST_RA = 2'b10;

    // writeback source
    localparam wb_src_t WB_ALU = 2'b00;
    localparam wb_src_t WB_MEM = 2'b01;
    localparam wb_src_t WB_PC4 = 2'b10;

    // opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // r-type funct codes
    localparam funct_t FN_SLL = 6'h00;
    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    localparam reg_idx_t REG_RA = 5'd31; // link register for jal

    // IDLE: free, HOLD: out_req up, DRAIN: waiting for out_ack to drop
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        HOLD  = 2'd1,
        DRAIN = 2'd2
    } issue_state_t;

endpackage

// ==== design/decode_ifs.sv ====
`timescale 1ns/1ps

// source operand read path, answered combinationally by the register file
interface reg_read_if;
    import decode_pkg::*;

    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;

    modport provider (input rs_idx, rt_idx, output rs_data, rt_data);
    modport user     (output rs_idx, rt_idx, input rs_data, rt_data);
endinterface

interface ctrl_bus_if;
    import decode_pkg::*;

    alu_op_t  alu_op;
    logic     alu_src_imm; // second alu operand from imm_ext
    dst_sel_t dst_sel;
    logic     reg_write;
    wb_src_t  wb_src;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     branch_ne;
    logic     jump;
    logic     jump_reg;
    logic     illegal;
    word_t    imm_ext;

    modport source (output alu_op, alu_src_imm, dst_sel, reg_write, wb_src, mem_read,
                    mem_write, branch, branch_ne, jump, jump_reg, illegal, imm_ext);
    modport sink   (input alu_op, alu_src_imm, dst_sel, reg_write, wb_src, mem_read,
                    mem_write, branch, branch_ne, jump, jump_reg, illegal, imm_ext);
endinterface

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_we,
    input  decode_pkg::reg_idx_t wb_idx,
    input  decode_pkg::word_t    wb_data,
    reg_read_if.provider         rd
);
    import decode_pkg::*;

    word_t regs [1:31]; // register zero has no storage

    // zero for r0, incoming data when the same register is being written
    function automatic word_t read_reg(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_we && (wb_idx == idx)) begin
            val = wb_data; // bypass
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_idx != '0)) begin
            regs[wb_idx] <= wb_data;
        end
    end

    always_comb begin
        rd.rs_data = read_reg(rd.rs_idx);
        rd.rt_data = read_reg(rd.rt_idx);
    end

endmodule

// ==== design/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
    input  decode_pkg::word_t inst,
    ctrl_bus_if.source        ctrl
);
    import decode_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    logic    is_nop;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign is_nop = (inst == '0); // sll r0,r0,0 encoding

    always_comb begin
        // safe defaults, nothing written
        ctrl.alu_op      = ALU_NOP;
        ctrl.alu_src_imm = 1'b0;
        ctrl.dst_sel     = DST_RT;
        ctrl.reg_write   = 1'b0;
        ctrl.wb_src      = WB_ALU;
        ctrl.mem_read    = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.branch      = 1'b0;
        ctrl.branch_ne   = 1'b0;
        ctrl.jump        = 1'b0;
        ctrl.jump_reg    = 1'b0;
        ctrl.illegal     = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                ctrl.dst_sel   = DST_RD;
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD: ctrl.alu_op = ALU_ADD;
                    FN_SUB: ctrl.alu_op = ALU_SUB;
                    FN_AND: ctrl.alu_op = ALU_AND;
                    FN_OR:  ctrl.alu_op = ALU_OR;
                    FN_SLT: ctrl.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl.alu_op    = is_nop ? ALU_NOP : ALU_SLL;
                        ctrl.reg_write = !is_nop;
                    end
                    FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.jump_reg  = 1'b1;
                    end
                    default: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.illegal   = 1'b1;
                    end
                endcase
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                case (opcode)
                    OP_SLTI: ctrl.alu_op = ALU_SLT;
                    OP_ANDI: ctrl.alu_op = ALU_AND;
                    OP_ORI:  ctrl.alu_op = ALU_OR;
                    OP_LUI:  ctrl.alu_op = ALU_LUI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctrl.alu_op      = ALU_ADD; // address = rs + imm
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.wb_src      = WB_MEM;
            end
            OP_SW: begin
                ctrl.alu_op      = ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.alu_op    = ALU_SUB; // compare rs and rt
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (opcode == OP_BNE);
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst_sel   = DST_RA;
                ctrl.wb_src    = WB_PC4;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

    // immediate extension
    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI: ctrl.imm_ext = {16'h0000, inst[15:0]};
            OP_LUI:          ctrl.imm_ext = {inst[15:0], 16'h0000};
            default:         ctrl.imm_ext = {{16{inst[15]}}, inst[15:0]};
        endcase
    end

endmodule

// ==== design/decode_issue.sv ====
`timescale 1ns/1ps

module decode_issue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_req,
    output logic                   in_ack,
    input  decode_pkg::word_t      in_inst,
    input  decode_pkg::word_t      in_pc4,
    reg_read_if.user               rd,
    output decode_pkg::word_t      inst,
    ctrl_bus_if.sink               ctrl,
    input  logic                   out_ack,
    output logic                   out_req,
    output decode_pkg::word_t      ex_rs_data,
    output decode_pkg::word_t      ex_rt_data,
    output decode_pkg::word_t      ex_imm,
    output decode_pkg::reg_idx_t   ex_rs_idx,
    output decode_pkg::reg_idx_t   ex_rt_idx,
    output decode_pkg::reg_idx_t   ex_dst_idx,
    output decode_pkg::shamt_t     ex_shamt,
    output decode_pkg::word_t      ex_pc4,
    output decode_pkg::word_t      ex_branch_target,
    output decode_pkg::word_t      ex_jump_target,
    output decode_pkg::alu_op_t    ex_alu_op,
    output logic                   ex_alu_src_imm,
    output logic                   ex_reg_write,
    output decode_pkg::wb_src_t    ex_wb_src,
    output logic                   ex_mem_read,
    output logic                   ex_mem_write,
    output logic                   ex_branch,
    output logic                   ex_branch_ne,
    output logic                   ex_jump,
    output logic                   ex_jump_reg,
    output logic                   ex_illegal
);
    import decode_pkg::*;

    issue_state_t state;
    logic         capture;
    reg_idx_t     dst_idx;
    jtarget_t     jfield;

    assign inst      = in_inst;
    assign rd.rs_idx = in_inst[25:21];
    assign rd.rt_idx = in_inst[20:16];
    assign jfield    = in_inst[25:0];
    assign out_req   = (state == HOLD);

    // both handshakes back at zero and a new request waiting
    assign capture = in_req && !in_ack && !out_req && !out_ack;

    always_comb begin
        case (ctrl.dst_sel)
            DST_RD:  dst_idx = in_inst[15:11];
            DST_RA:  dst_idx = REG_RA;
            default: dst_idx = in_inst[20:16];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            in_ack <= 1'b0;
        end else begin
            if (capture) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end
            case (state)
                HOLD:    if (out_ack) state <= DRAIN;
                DRAIN:   if (capture) state <= HOLD;
                         else if (!out_ack) state <= IDLE;
                default: if (capture) state <= HOLD;
            endcase
        end
    end

    // output bundle, held until the next capture
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {ex_rs_data, ex_rt_data, ex_imm, ex_pc4, ex_branch_target, ex_jump_target} <= '0;
            {ex_rs_idx, ex_rt_idx, ex_dst_idx, ex_shamt, ex_alu_op, ex_wb_src} <= '0;
            {ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write} <= '0;
            {ex_branch, ex_branch_ne, ex_jump, ex_jump_reg, ex_illegal} <= '0;
        end else if (capture) begin
            ex_rs_data       <= rd.rs_data;
            ex_rt_data       <= rd.rt_data;
            ex_imm           <= ctrl.imm_ext;
            ex_rs_idx        <= in_inst[25:21];
            ex_rt_idx        <= in_inst[20:16];
            ex_dst_idx       <= dst_idx;
            ex_shamt         <= in_inst[10:6];
            ex_pc4           <= in_pc4;
            ex_branch_target <= in_pc4 + (ctrl.imm_ext << 2);
            ex_jump_target   <= {in_pc4[31:28], jfield, 2'b00};
            ex_alu_op        <= ctrl.alu_op;
            ex_alu_src_imm   <= ctrl.alu_src_imm;
            ex_reg_write     <= ctrl.reg_write;
            ex_wb_src        <= ctrl.wb_src;
            ex_mem_read      <= ctrl.mem_read;
            ex_mem_write     <= ctrl.mem_write;
            ex_branch        <= ctrl.branch;
            ex_branch_ne     <= ctrl.branch_ne;
            ex_jump          <= ctrl.jump;
            ex_jump_reg      <= ctrl.jump_reg;
            ex_illegal       <= ctrl.illegal;
        end
    end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_req,
    output logic                   in_ack,
    input  decode_pkg::word_t      in_inst,
    input  decode_pkg::word_t      in_pc4,
    input  logic                   wb_we,
    input  decode_pkg::reg_idx_t   wb_idx,
    input  decode_pkg::word_t      wb_data,
    output logic                   out_req,
    input  logic                   out_ack,
    output decode_pkg::word_t      ex_rs_data,
    output decode_pkg::word_t      ex_rt_data,
    output decode_pkg::word_t      ex_imm,
    output decode_pkg::reg_idx_t   ex_rs_idx,
    output decode_pkg::reg_idx_t   ex_rt_idx,
    output decode_pkg::reg_idx_t   ex_dst_idx,
    output decode_pkg::shamt_t     ex_shamt,
    output decode_pkg::word_t      ex_pc4,
    output decode_pkg::word_t      ex_branch_target,
    output decode_pkg::word_t      ex_jump_target,
    output decode_pkg::alu_op_t    ex_alu_op,
    output logic                   ex_alu_src_imm,
    output logic                   ex_reg_write,
    output decode_pkg::wb_src_t    ex_wb_src,
    output logic                   ex_mem_read,
    output logic                   ex_mem_write,
    output logic                   ex_branch,
    output logic                   ex_branch_ne,
    output logic                   ex_jump,
    output logic                   ex_jump_reg,
    output logic                   ex_illegal
);

    reg_read_if        rd_bus ();
    ctrl_bus_if        ctrl_bus ();
    decode_pkg::word_t dec_inst; // instruction fed to the decoder

    reg_file regs0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_we   (wb_we),
        .wb_idx  (wb_idx),
        .wb_data (wb_data),
        .rd      (rd_bus.provider)
    );

    control_decoder ctrl0 (
        .inst (dec_inst),
        .ctrl (ctrl_bus.source)
    );

    decode_issue issue0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_req           (in_req),
        .in_ack           (in_ack),
        .in_inst          (in_inst),
        .in_pc4           (in_pc4),
        .rd               (rd_bus.user),
        .inst             (dec_inst),
        .ctrl             (ctrl_bus.sink),
        .out_ack          (out_ack),
        .out_req          (out_req),
        .ex_rs_data       (ex_rs_data),
        .ex_rt_data       (ex_rt_data),
        .ex_imm           (ex_imm),
        .ex_rs_idx        (ex_rs_idx),
        .ex_rt_idx        (ex_rt_idx),
        .ex_dst_idx       (ex_dst_idx),
        .ex_shamt         (ex_shamt),
        .ex_pc4           (ex_pc4),
        .ex_branch_target (ex_branch_target),
        .ex_jump_target   (ex_jump_target),
        .ex_alu_op        (ex_alu_op),
        .ex_alu_src_imm   (ex_alu_src_imm),
        .ex_reg_write     (ex_reg_write),
        .ex_wb_src        (ex_wb_src),
        .ex_mem_read      (ex_mem_read),
        .ex_mem_write     (ex_mem_write),
        .ex_branch        (ex_branch),
        .ex_branch_ne     (ex_branch_ne),
        .ex_jump          (ex_jump),
        .ex_jump_reg      (ex_jump_reg),
        .ex_illegal       (ex_illegal)
    );

endmodule

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TXN      = 32; // instructions issued by the driver

    typedef struct packed {
        word_t    rs_data, rt_data, imm;
        reg_idx_t rs_idx, rt_idx, dst_idx;
        shamt_t   shamt;
        word_t    pc4, branch_target, jump_target;
        alu_op_t  alu_op;
        logic     alu_src_imm, reg_write;
        wb_src_t  wb_src;
        logic     mem_read, mem_write, branch, branch_ne, jump, jump_reg, illegal;
    } bundle_t;

    logic     clk = 1'b0;
    logic     rst_n, in_req, in_ack, wb_we, out_req, out_ack;
    word_t    in_inst, in_pc4, wb_data;
    reg_idx_t wb_idx;
    word_t    ex_rs_data, ex_rt_data, ex_imm, ex_pc4, ex_branch_target, ex_jump_target;
    reg_idx_t ex_rs_idx, ex_rt_idx, ex_dst_idx;
    shamt_t   ex_shamt;
    alu_op_t  ex_alu_op;
    wb_src_t  ex_wb_src;
    logic     ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic     ex_branch, ex_branch_ne, ex_jump, ex_jump_reg, ex_illegal;

    word_t       shadow [32];       // expected register contents
    bundle_t     exp_log [$];
    string       name_log [$];
    int          cmp_count = 0;
    int          rx_count = 0;
    int          stall_cycles = -1; // fixed out_ack delay when not negative
    integer      seed = 32'hd880ef02;
    logic [15:0] imm_pool [14];

    decode_stage dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_shamt(input string name, input shamt_t exp, input shamt_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_wb_src(input string name, input wb_src_t exp, input wb_src_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %b, actual %b", name, exp, act));
    endtask

    function automatic word_t rtype(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, shamt_t sh,
                                    funct_t fn);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype(opcode_t op, jtarget_t target);
        return {op, target};
    endfunction

    // expected bundle from the instruction, pc+4 and the shadow registers
    function automatic bundle_t decode_model(input word_t inst, input word_t pc4);
        bundle_t b;
        opcode_t op;
        funct_t  fn;
        op = inst[31:26];
        fn = inst[5:0];
        b = '0;
        b.rs_idx  = inst[25:21];
        b.rt_idx  = inst[20:16];
        b.rs_data = shadow[inst[25:21]];
        b.rt_data = shadow[inst[20:16]];
        b.shamt   = inst[10:6];
        b.pc4     = pc4;
        b.dst_idx = inst[20:16];
        b.alu_op  = ALU_NOP;
        b.wb_src  = WB_ALU;
        b.imm     = {{16{inst[15]}}, inst[15:0]};
        if (op == OP_ANDI || op == OP_ORI)
            b.imm = {16'h0000, inst[15:0]};
        else if (op == OP_LUI)
            b.imm = {inst[15:0], 16'h0000};
        b.branch_target = pc4 + {b.imm[29:0], 2'b00};
        b.jump_target   = {pc4[31:28], inst[25:0], 2'b00};
        case (op)
            OP_RTYPE: begin
                b.dst_idx   = inst[15:11];
                b.reg_write = 1'b1;
                case (fn)
                    FN_ADD: b.alu_op = ALU_ADD;
                    FN_SUB: b.alu_op = ALU_SUB;
                    FN_AND: b.alu_op = ALU_AND;
                    FN_OR:  b.alu_op = ALU_OR;
                    FN_SLT: b.alu_op = ALU_SLT;
                    FN_SLL: b.alu_op = ALU_SLL;
                    FN_JR: begin
                        b.reg_write = 1'b0;
                        b.jump_reg  = 1'b1;
                    end
                    default: begin
                        b.reg_write = 1'b0;
                        b.illegal   = 1'b1;
                    end
                endcase
                if (inst == '0) begin // nop writes nothing
                    b.alu_op    = ALU_NOP;
                    b.reg_write = 1'b0;
                end
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
                b.alu_src_imm = 1'b1;
                b.reg_write   = 1'b1;
                b.mem_read    = (op == OP_LW);
                b.wb_src      = (op == OP_LW) ? WB_MEM : WB_ALU;
                b.alu_op      = (op == OP_SLTI) ? ALU_SLT : (op == OP_ANDI) ? ALU_AND :
                                (op == OP_ORI) ? ALU_OR : (op == OP_LUI) ? ALU_LUI : ALU_ADD;
            end
            OP_SW: begin
                b.alu_op      = ALU_ADD;
                b.alu_src_imm = 1'b1;
                b.mem_write   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                b.alu_op    = ALU_SUB; // operands compared by subtraction
                b.branch    = 1'b1;
                b.branch_ne = (op == OP_BNE);
            end
            OP_J: b.jump = 1'b1;
            OP_JAL: begin
                b.jump      = 1'b1;
                b.reg_write = 1'b1;
                b.dst_idx   = REG_RA;
                b.wb_src    = WB_PC4;
            end
            default: b.illegal = 1'b1;
        endcase
        return b;
    endfunction

    function automatic bundle_t read_bundle();
        return {ex_rs_data, ex_rt_data, ex_imm, ex_rs_idx, ex_rt_idx, ex_dst_idx, ex_shamt,
                ex_pc4, ex_branch_target, ex_jump_target, ex_alu_op, ex_alu_src_imm,
                ex_reg_write, ex_wb_src, ex_mem_read, ex_mem_write, ex_branch, ex_branch_ne,
                ex_jump, ex_jump_reg, ex_illegal};
    endfunction

    task automatic compare_bundle(input string name, input bundle_t exp);
        check_word({name, ".rs_data"}, exp.rs_data, ex_rs_data);
        check_word({name, ".rt_data"}, exp.rt_data, ex_rt_data);
        check_word({name, ".imm"}, exp.imm, ex_imm);
        check_reg_idx({name, ".rs_idx"}, exp.rs_idx, ex_rs_idx);
        check_reg_idx({name, ".rt_idx"}, exp.rt_idx, ex_rt_idx);
        check_reg_idx({name, ".dst_idx"}, exp.dst_idx, ex_dst_idx);
        check_shamt({name, ".shamt"}, exp.shamt, ex_shamt);
        check_word({name, ".pc4"}, exp.pc4, ex_pc4);
        check_word({name, ".branch_target"}, exp.branch_target, ex_branch_target);
        check_word({name, ".jump_target"}, exp.jump_target, ex_jump_target);
        check_alu_op({name, ".alu_op"}, exp.alu_op, ex_alu_op);
        check_flag({name, ".alu_src_imm"}, exp.alu_src_imm, ex_alu_src_imm);
        check_flag({name, ".reg_write"}, exp.reg_write, ex_reg_write);
        check_wb_src({name, ".wb_src"}, exp.wb_src, ex_wb_src);
        check_flag({name, ".mem_read"}, exp.mem_read, ex_mem_read);
        check_flag({name, ".mem_write"}, exp.mem_write, ex_mem_write);
        check_flag({name, ".branch"}, exp.branch, ex_branch);
        check_flag({name, ".branch_ne"}, exp.branch_ne, ex_branch_ne);
        check_flag({name, ".jump"}, exp.jump, ex_jump);
        check_flag({name, ".jump_reg"}, exp.jump_reg, ex_jump_reg);
        check_flag({name, ".illegal"}, exp.illegal, ex_illegal);
    endtask

    // bundle must keep the expected value for the whole output handshake
    task automatic check_stable(input string name, input bundle_t exp);
        bundle_t act;
        act = read_bundle();
        if (act !== exp)
            abort_run($sformatf("Error %s.held: expected %h, actual %h", name, exp, act));
    endtask

    task automatic write_reg(input reg_idx_t idx, input word_t data);
        @(posedge clk);
        wb_we   <= 1'b1;
        wb_idx  <= idx;
        wb_data <= data;
        @(posedge clk);
        wb_we <= 1'b0;
        if (idx != '0)
            shadow[idx] = data;
    endtask

    task automatic finish_input();
        do @(negedge clk); while (!in_ack);
        @(posedge clk);
        in_req <= 1'b0;
        do @(negedge clk); while (in_ack);
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (in_ack || out_req || out_ack);
    endtask

    task automatic issue(input string name, input word_t inst, input word_t pc4);
        exp_log.push_back(decode_model(inst, pc4));
        name_log.push_back(name);
        @(posedge clk);
        in_req  <= 1'b1;
        in_inst <= inst;
        in_pc4  <= pc4;
        finish_input();
    endtask

    // writeback lands on the capture edge itself
    task automatic issue_with_write(input string name, input word_t inst, input word_t pc4,
                                    input reg_idx_t idx, input word_t data);
        wait_idle();
        if (idx != '0)
            shadow[idx] = data;
        exp_log.push_back(decode_model(inst, pc4));
        name_log.push_back(name);
        @(posedge clk);
        in_req  <= 1'b1;
        in_inst <= inst;
        in_pc4  <= pc4;
        wb_we   <= 1'b1;
        wb_idx  <= idx;
        wb_data <= data;
        @(posedge clk);
        wb_we <= 1'b0;
        finish_input();
    endtask

    initial begin : driver
        opcode_t imm_ops [7];
        imm_ops = '{OP_ADDI, OP_SLTI, OP_LW, OP_SW, OP_ANDI, OP_ORI, OP_LUI};
        rst_n   = 1'b0;
        in_req  = 1'b0;
        in_inst = '0;
        in_pc4  = '0;
        wb_we   = 1'b0;
        wb_idx  = '0;
        wb_data = '0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        for (int i = 0; i < 14; i++) begin
            imm_pool[i]     = $random(seed);
            imm_pool[i][15] = i[0]; // alternate the sign bit
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        write_reg(5'd1, 32'h1234_5678);
        write_reg(5'd2, 32'h0fed_cba9);
        write_reg(5'd3, 32'h8000_0001);
        write_reg(5'd4, 32'hffff_fff0);
        write_reg(5'd5, 32'h0000_4000);
        issue("add", rtype(5'd1, 5'd2, 5'd6, 5'd0, FN_ADD), 32'h0040_0004);
        issue("sub", rtype(5'd3, 5'd4, 5'd7, 5'd0, FN_SUB), 32'h0040_0008);
        issue("and", rtype(5'd1, 5'd4, 5'd8, 5'd0, FN_AND), 32'h0040_000c);
        issue("or", rtype(5'd2, 5'd3, 5'd9, 5'd0, FN_OR), 32'h0040_0010);
        issue("slt", rtype(5'd3, 5'd1, 5'd10, 5'd0, FN_SLT), 32'h0040_0014);
        issue("sll", rtype(5'd0, 5'd2, 5'd11, 5'd7, FN_SLL), 32'h0040_0018);
        issue("jr", rtype(5'd5, 5'd0, 5'd0, 5'd0, FN_JR), 32'h0040_001c);

        for (int i = 0; i < 14; i++) begin
            issue($sformatf("imm%0d", i),
                  itype(imm_ops[i % 7], reg_idx_t'(1 + i % 5), reg_idx_t'(12 + i), imm_pool[i]),
                  32'h0040_0100 + 4 * i);
        end

        issue("beq", itype(OP_BEQ, 5'd1, 5'd2, 16'h0010), 32'h0040_1000);
        issue("bne", itype(OP_BNE, 5'd3, 5'd4, 16'hfff8), 32'h0040_2000);
        issue("j", jtype(OP_J, 26'h012_3456), 32'ha000_0010);
        issue("jal", jtype(OP_JAL, 26'h3ff_fffc), 32'h5000_0000);

        write_reg(5'd0, 32'hdead_beef); // must not stick
        issue("zero_src", rtype(5'd0, 5'd0, 5'd13, 5'd0, FN_OR), 32'h0040_0300);
        issue_with_write("bypass", rtype(5'd20, 5'd1, 5'd21, 5'd0, FN_ADD), 32'h0040_0304,
                         5'd20, 32'hcafe_f00d);

        // both see the long out_ack delay and b waits with in_req high
        wait_idle();
        stall_cycles = 12;
        issue("stall_a", itype(OP_ADDI, 5'd2, 5'd22, 16'h7fff), 32'h0040_0400);
        issue("stall_b", rtype(5'd3, 5'd4, 5'd23, 5'd0, FN_SUB), 32'h0040_0404);
        stall_cycles = -1;

        issue("nop", 32'h0000_0000, 32'h0040_0500);
        issue("bad_opcode", itype(6'h3f, 5'd1, 5'd2, 16'h1234), 32'h0040_0504);
        issue("bad_funct", rtype(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f), 32'h0040_0508);

        wait_idle();
        if (cmp_count != NUM_TXN || exp_log.size() != NUM_TXN) begin
            abort_run("not every issued instruction came out of the decode stage");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

    initial begin : compare
        logic prev_req;
        prev_req = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req === 1'b1 && !prev_req) begin
                if (cmp_count >= exp_log.size())
                    abort_run("out_req rose with no instruction outstanding");
                compare_bundle(name_log[cmp_count], exp_log[cmp_count]);
                cmp_count++;
            end
            prev_req = (out_req === 1'b1);
        end
    end

    initial begin : receiver
        int delay;
        out_ack = 1'b0;
        forever begin
            do @(negedge clk); while (out_req !== 1'b1);
            delay = (stall_cycles >= 0) ? stall_cycles : $unsigned($random(seed)) % 7;
            repeat (delay) begin
                @(negedge clk);
                check_stable(name_log[rx_count], exp_log[rx_count]);
            end
            @(posedge clk);
            out_ack <= 1'b1;
            do begin
                @(negedge clk);
                check_stable(name_log[rx_count], exp_log[rx_count]);
            end while (out_req);
            @(posedge clk);
            out_ack <= 1'b0;
            rx_count++;
        end
    end

    // a new capture needs the output side back at zero
    initial begin : handshake_monitor
        logic prev_in_ack;
        logic prev_busy;
        prev_in_ack = 1'b0;
        prev_busy   = 1'b0;
        forever begin
            @(negedge clk);
            if (in_ack === 1'b1 && !prev_in_ack && prev_busy)
                abort_run("in_ack rose while the output handshake was still busy");
            prev_in_ack = (in_ack === 1'b1);
            prev_busy   = (out_req === 1'b1) || out_ack;
        end
    end

    initial begin : watchdog
        #(RESET_CYCLES * CLK_PERIOD + NUM_TXN * 20 * CLK_PERIOD);
        abort_run("timeout, the decode stage stopped handshaking");
    end

endmodule

// ==== tb.f ====
design/decode_pkg.sv
design/decode_ifs.sv
design/reg_file.sv
design/control_decoder.sv
design/decode_issue.sv
design/decode_stage.sv
testbench/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

dependencies: {}

sources:
  - files:
      - design/decode_pkg.sv
      - design/decode_ifs.sv
      - design/reg_file.sv
      - design/control_decoder.sv
      - design/decode_issue.sv
      - design/decode_stage.sv
  - target: test
    files:
      - testbench/tb_decode_stage.sv
